/* hw/mcu_periph_pkg.sv */
// 6801-family peripheral map
// Port addresses and masks, RAM window, timer register map and reset values
package mcu_periph_pkg;

  // ********************
  // Parallel ports
  // ********************
  localparam int num_ports = 3;

  // Ports 1, 2 and 6 in generate order
  localparam logic [15:0] port_addr [num_ports] = '{16'h0002, 16'h0003, 16'h0017};
  localparam logic [7:0]  port_mask [num_ports] = '{8'hff, 8'h1f, 8'hff};

  // ********************
  // Memory windows
  // ********************
  localparam logic [15:0] ram_start = 16'h0040;
  localparam logic [15:0] ram_end   = 16'h013f;

  localparam logic [1:0] rom_base_bits = 2'b11;  // $C000-$FFFF

  // ********************
  // Timer registers
  // ********************
  localparam logic [4:0] tmr_rg5  = 5'h05;  // Scratch
  localparam logic [4:0] tmr_tcsr = 5'h08;
  localparam logic [4:0] tmr_frch = 5'h09;
  localparam logic [4:0] tmr_frcl = 5'h0a;
  localparam logic [4:0] tmr_ocrh = 5'h0b;
  localparam logic [4:0] tmr_ocrl = 5'h0c;
  localparam logic [4:0] tmr_icrh = 5'h0d;
  localparam logic [4:0] tmr_icrl = 5'h0e;
  localparam logic [4:0] tmr_rmc  = 5'h14;  // RAM control

  localparam logic [15:0] ocr_reset = 16'hffff;
  localparam logic [15:0] icr_reset = 16'hffff;
  localparam logic [7:0]  rmc_reset = 8'h40;

endpackage

/* hw/bus_decode.sv */
// Internal address decoder
// Turns the 16-bit bus address into PROM, RAM, timer and port selects
`timescale 1ns/1ps

module bus_decode
  import mcu_periph_pkg::*;
(
  input  logic [15:0]          ad,
  output logic                 rom_sel,
  output logic                 ram_sel,
  output logic                 timer_sel,
  output logic [num_ports-1:0] port_sel
);

  logic       page0;     // $0000-$001F holds all registers
  logic [4:0] reg_lo;

  assign page0  = (ad[15:5] == 11'd0);
  assign reg_lo = ad[4:0];

  // ********************
  // Memory windows
  // ********************
  assign rom_sel = (ad[15:14] == rom_base_bits);
  assign ram_sel = (ad >= ram_start) && (ad <= ram_end);

  // ********************
  // Register page
  // ********************
  // Timer block is split: scratch, the $08-$0E run and RAM control
  always_comb begin
    timer_sel = 1'b0;
    if (page0) begin
      if (reg_lo == tmr_rg5 || reg_lo == tmr_rmc)
        timer_sel = 1'b1;
      else if (reg_lo >= tmr_tcsr && reg_lo <= tmr_icrl)
        timer_sel = 1'b1;
    end
  end

  always_comb begin
    for (int k = 0; k < num_ports; k++) begin
      port_sel[k] = (ad == port_addr[k]);  // Full compare, no mirrors
    end
  end

  // Windows must never overlap, or the read selector would hide a device
  always_comb begin
    a_sel_onehot: assert #0 ($onehot0({rom_sel, ram_sel, timer_sel, port_sel}))
      else $error("bus_decode: overlapping selects for ad=%h", ad);
  end

endmodule

/* hw/io_port.sv */
// Parallel I/O port
// Output latch plus pin read, with unimplemented bits pinned high
`timescale 1ns/1ps

module io_port
  import mcu_periph_pkg::*;
#(
  parameter int idx = 0  // Selects the mask from the port table
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       sel,
  input  logic       wr,
  input  logic [7:0] wdata,
  input  logic [7:0] pin,
  output logic [7:0] pout,
  output logic [7:0] rdata
);

  localparam logic [7:0] mask = port_mask[idx];

  logic       wr_en;
  logic [7:0] out_q;

  assign wr_en = sel & wr;

  // ********************
  // Output latch
  // ********************
  // Comes out of reset driving ones on every implemented pin
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_q <= mask;
    end else if (wr_en) begin
      out_q <= wdata & mask;  // Missing bits stay clear
    end
  end

  assign pout = out_q;

  // ********************
  // Read path
  // ********************
  // Pins are read directly, not the latch
  assign rdata = pin | ~mask;

endmodule

/* hw/work_ram.sv */
// Built-in work RAM
// 256 bytes behind the $0040-$013F window, registered read
`timescale 1ns/1ps

module work_ram (
  input  logic       clk,
  input  logic       sel,
  input  logic       wr,
  input  logic [7:0] addr,
  input  logic [7:0] wdata,
  output logic [7:0] rdata
);

  // Window $0040-$00FF lands on 40-FF and $0100-$013F wraps to 00-3F,
  // so the low address byte alone is a unique index
  logic [7:0] mem [0:255];
  logic       wr_en;

  assign wr_en = sel & wr;

  // ********************
  // Storage
  // ********************
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= wdata;
    end else begin
      rdata <= mem[addr];  // Valid the cycle after addr
    end
  end

endmodule

/* hw/frc_timer.sv */
// Free-running counter timer
// Counter, output compare, input capture, scratch and RAM control registers
// Output compare match raises irq2 when enabled
`timescale 1ns/1ps

module frc_timer
  import mcu_periph_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cen,
  input  logic       sel,
  input  logic       wr,
  input  logic [4:0] reg_addr,
  input  logic [7:0] wdata,
  output logic [7:0] rdata,
  output logic       irq2
);

  logic [15:0] frc;      // Free-running counter
  logic [7:0]  frc_buf;  // High byte waits here until the low byte write
  logic [15:0] ocr;
  logic [15:0] icr;
  logic [7:0]  rg5;
  logic [7:0]  rmc;
  logic        oce;      // Compare interrupt enable
  logic        ocf;      // Compare flag
  logic        wr_en;
  logic        ocr_wr;

  assign wr_en  = sel & wr;
  assign ocr_wr = wr_en && (reg_addr == tmr_ocrh || reg_addr == tmr_ocrl);

  // ********************
  // Control registers
  // ********************
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frc <= 16'h0000;
      ocr <= ocr_reset;
      icr <= icr_reset;
      rmc <= rmc_reset;
      oce <= 1'b0;
    end else begin
      if (cen) frc <= frc + 16'd1;
      if (wr_en) begin
        case (reg_addr)
          tmr_tcsr: oce <= wdata[3];
          tmr_frcl: frc <= {frc_buf, wdata};  // Load wins over the count
          tmr_ocrh: ocr[15:8] <= wdata;
          tmr_ocrl: ocr[7:0] <= wdata;
          tmr_icrh: icr[15:8] <= wdata;
          tmr_icrl: icr[7:0] <= wdata;
          tmr_rmc:  rmc <= {wdata[7:6], 6'h00};
          default: ;
        endcase
      end
    end
  end

  // Scratch byte and counter buffer
  always_ff @(posedge clk) begin
    if (wr_en && reg_addr == tmr_rg5) rg5 <= wdata;
    if (wr_en && reg_addr == tmr_frch) frc_buf <= wdata;
  end

  // ********************
  // Output compare
  // ********************
  // Match is taken on the count before this edge's increment
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ocf <= 1'b0;
    end else if (ocr_wr) begin
      ocf <= 1'b0;  // Compare write beats a same-edge match
    end else if (cen && frc == ocr) begin
      ocf <= 1'b1;
    end
  end

  assign irq2 = ocf & oce;

  // ********************
  // Read back
  // ********************
  always_comb begin
    case (reg_addr)
      tmr_rg5:  rdata = rg5;
      tmr_tcsr: rdata = {1'b0, ocf, 1'b1, 1'b0, oce, 3'b000};
      tmr_frch: rdata = frc[15:8];  // Live count
      tmr_frcl: rdata = frc[7:0];
      tmr_ocrh: rdata = ocr[15:8];
      tmr_ocrl: rdata = ocr[7:0];
      tmr_icrh: rdata = icr[15:8];
      tmr_icrl: rdata = icr[7:0];
      tmr_rmc:  rdata = rmc;
      default:  rdata = 8'h00;
    endcase
  end

  a_irq_needs_enable: assert property (@(posedge clk) disable iff (rst) irq2 |-> oce)
    else $error("frc_timer: irq2 high with compare interrupt disabled");

endmodule

/* hw/read_mux.sv */
// Read data selector
// Picks the byte for the bus master: PROM, RAM, port, timer, then external bus
`timescale 1ns/1ps

module read_mux
  import mcu_periph_pkg::*;
(
  input  logic                 rom_sel,
  input  logic                 ram_sel,
  input  logic                 timer_sel,
  input  logic [num_ports-1:0] port_sel,
  input  logic [7:0]           rom_data,
  input  logic [7:0]           ram_data,
  input  logic [7:0]           timer_data,
  input  logic [7:0]           din,
  input  logic [7:0]           port_data [num_ports],
  output logic [7:0]           rd_data
);

  logic [7:0] port_byte;

  // Ports are one-hot, so an OR of the gated bytes is enough
  always_comb begin
    port_byte = 8'h00;
    for (int k = 0; k < num_ports; k++) begin
      if (port_sel[k]) port_byte = port_byte | port_data[k];
    end
  end

  // ********************
  // Priority chain
  // ********************
  always_comb begin
    if (rom_sel)
      rd_data = rom_data;   // Internal PROM first
    else if (ram_sel)
      rd_data = ram_data;
    else if (|port_sel)
      rd_data = port_byte;
    else if (timer_sel)
      rd_data = timer_data;
    else
      rd_data = din;        // Nothing internal, external bus
  end

  always_comb begin
    a_port_onehot: assert #0 ($onehot0(port_sel))
      else $error("read_mux: more than one port selected (%b)", port_sel);
  end

endmodule

/* hw/mcu_periph_top.sv */
// 6801-family on-chip peripherals
// Decoder, work RAM, ports 1/2/6, free-running timer and read selector
`timescale 1ns/1ps

module mcu_periph_top
  import mcu_periph_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cen,
  input  logic        wr,
  input  logic [15:0] ad,
  input  logic [7:0]  dout,
  input  logic [7:0]  din,
  output logic [7:0]  rd_data,
  output logic [13:0] rom_addr,
  input  logic [7:0]  rom_data,
  output logic        rom_cs,
  output logic        ba,
  output logic        irq2,
  input  logic [7:0]  p1_din,
  input  logic [4:0]  p2_din,
  input  logic [7:0]  p6_din,
  output logic [7:0]  p1_dout,
  output logic [4:0]  p2_dout,
  output logic [7:0]  p6_dout
);

  logic                 rom_sel;
  logic                 ram_sel;
  logic                 timer_sel;
  logic [num_ports-1:0] port_sel;
  logic [7:0]           ram_data;
  logic [7:0]           timer_data;
  logic [7:0]           port_pin  [num_ports];
  logic [7:0]           port_pout [num_ports];
  logic [7:0]           port_rd   [num_ports];

  // ********************
  // PROM side
  // ********************
  assign rom_cs   = rom_sel;
  assign ba       = rom_sel;  // Bus free while the PROM is read
  assign rom_addr = ad[13:0];

  bus_decode u_decode (
    .ad        (ad),
    .rom_sel   (rom_sel),
    .ram_sel   (ram_sel),
    .timer_sel (timer_sel),
    .port_sel  (port_sel)
  );

  work_ram u_ram (
    .clk   (clk),
    .sel   (ram_sel),
    .wr    (wr),
    .addr  (ad[7:0]),
    .wdata (dout),
    .rdata (ram_data)
  );

  // ********************
  // Ports 1, 2, 6
  // ********************
  assign port_pin[0] = p1_din;
  assign port_pin[1] = {3'b111, p2_din};  // Port 2 has five pins
  assign port_pin[2] = p6_din;

  for (genvar k = 0; k < num_ports; k++) begin : g_port
    io_port #(.idx(k)) u_port (
      .clk   (clk),
      .rst   (rst),
      .sel   (port_sel[k]),
      .wr    (wr),
      .wdata (dout),
      .pin   (port_pin[k]),
      .pout  (port_pout[k]),
      .rdata (port_rd[k])
    );
  end

  assign p1_dout = port_pout[0];
  assign p2_dout = port_pout[1][4:0];
  assign p6_dout = port_pout[2];

  frc_timer u_timer (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .sel      (timer_sel),
    .wr       (wr),
    .reg_addr (ad[4:0]),
    .wdata    (dout),
    .rdata    (timer_data),
    .irq2     (irq2)
  );

  read_mux u_rdmux (
    .rom_sel    (rom_sel),
    .ram_sel    (ram_sel),
    .timer_sel  (timer_sel),
    .port_sel   (port_sel),
    .rom_data   (rom_data),
    .ram_data   (ram_data),
    .timer_data (timer_data),
    .din        (din),
    .port_data  (port_rd),
    .rd_data    (rd_data)
  );

endmodule

/* sim/tb_mcu_periph.sv */
// Testbench for the 6801-family peripheral subsystem
// Random bus master with a cycle-level model of ports, RAM and timer
`timescale 1ns/1ps

module tb_mcu_periph
  import mcu_periph_pkg::*;
();

  localparam int n_port_ops    = 60;
  localparam int n_ram_ops     = 80;
  localparam int n_timer_ops   = 80;
  localparam int n_prio_ops    = 40;
  localparam int flag_wait_max = 200;
  localparam int total_ops     = n_port_ops + n_ram_ops + n_timer_ops + n_prio_ops
                                 + flag_wait_max + 20;
  localparam int watchdog_ns   = total_ops * 3 * 20 + 1000;
  localparam logic [4:0] tmr_regs [9] = '{tmr_rg5, tmr_tcsr, tmr_frch, tmr_frcl,
                                          tmr_ocrh, tmr_ocrl, tmr_icrh, tmr_icrl, tmr_rmc};

  logic clk, rst, cen, wr, rom_cs, ba, irq2;
  logic [15:0] ad;
  logic [13:0] rom_addr;
  logic [7:0]  dout, din, rom_data, rd_data, p1_din, p6_din, p1_dout, p6_dout;
  logic [4:0]  p2_din, p2_dout;

  // Reference model state
  logic [7:0]  m_ram [0:255];
  logic [7:0]  m_port [num_ports];
  logic [15:0] m_frc, m_ocr, m_icr;
  logic [7:0]  m_buf, m_rg5, m_rmc;
  logic        m_oce, m_ocf;
  logic [15:0] ram_written [$];
  integer      seed;

  mcu_periph_top UUT (
    .clk(clk), .rst(rst), .cen(cen), .wr(wr), .ad(ad), .dout(dout), .din(din),
    .rd_data(rd_data), .rom_addr(rom_addr), .rom_data(rom_data), .rom_cs(rom_cs),
    .ba(ba), .irq2(irq2), .p1_din(p1_din), .p2_din(p2_din), .p6_din(p6_din),
    .p1_dout(p1_dout), .p2_dout(p2_dout), .p6_dout(p6_dout)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ********************
  // Reference model
  // ********************
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < num_ports; k++) m_port[k] <= port_mask[k];
      m_frc <= 16'h0000;
      m_ocr <= ocr_reset;
      m_icr <= icr_reset;
      m_rmc <= rmc_reset;
      m_oce <= 1'b0;
      m_ocf <= 1'b0;
    end else begin
      if (cen) m_frc <= m_frc + 16'd1;
      if (cen && m_frc == m_ocr) m_ocf <= 1'b1;  // Old count against old compare
      if (wr) begin
        if (ad >= ram_start && ad <= ram_end) m_ram[ad[7:0]] <= dout;
        for (int k = 0; k < num_ports; k++)
          if (ad == port_addr[k]) m_port[k] <= dout & port_mask[k];
        if (ad[15:5] == 11'd0) begin
          case (ad[4:0])
            tmr_rg5:  m_rg5 <= dout;
            tmr_tcsr: m_oce <= dout[3];
            tmr_frch: m_buf <= dout;
            tmr_frcl: m_frc <= {m_buf, dout};
            tmr_ocrh: begin
              m_ocr[15:8] <= dout;
              m_ocf <= 1'b0;
            end
            tmr_ocrl: begin
              m_ocr[7:0] <= dout;
              m_ocf <= 1'b0;
            end
            tmr_icrh: m_icr[15:8] <= dout;
            tmr_icrl: m_icr[7:0] <= dout;
            tmr_rmc:  m_rmc <= dout & 8'hc0;
            default: ;
          endcase
        end
      end
    end
  end

  function automatic logic [15:0] treg(input logic [4:0] r);
    return {11'd0, r};
  endfunction

  // Byte the master should see for address a in the current cycle
  function automatic logic [7:0] expect_read(input logic [15:0] a);
    logic [7:0] v;
    v = din;
    if (a[15:14] == rom_base_bits) v = rom_data;
    else if (a >= ram_start && a <= ram_end) v = m_ram[a[7:0]];
    else if (a == port_addr[0]) v = p1_din;
    else if (a == port_addr[1]) v = {3'b111, p2_din};  // Missing pins read high
    else if (a == port_addr[2]) v = p6_din;
    else if (a[15:5] == 11'd0) begin
      case (a[4:0])
        tmr_rg5:  v = m_rg5;
        tmr_tcsr: v = {1'b0, m_ocf, 1'b1, 1'b0, m_oce, 3'b000};
        tmr_frch: v = m_frc[15:8];
        tmr_frcl: v = m_frc[7:0];
        tmr_ocrh: v = m_ocr[15:8];
        tmr_ocrl: v = m_ocr[7:0];
        tmr_icrh: v = m_icr[15:8];
        tmr_icrl: v = m_icr[7:0];
        tmr_rmc:  v = m_rmc;
        default:  v = din;
      endcase
    end
    return v;
  endfunction

  task automatic check_eq(input string name, input logic [15:0] actual,
                          input logic [15:0] expected);
    if (actual !== expected) begin
      $display("error %s: got %h, expected %h", name, actual, expected);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic check_cycle(input logic check_rd);
    check_eq("p1_dout", p1_dout, m_port[0]);
    check_eq("p2_dout", p2_dout, m_port[1][4:0]);
    check_eq("p6_dout", p6_dout, m_port[2]);
    check_eq("irq2", irq2, m_ocf & m_oce);
    check_eq("rom_cs", rom_cs, ad[15:14] == rom_base_bits);
    check_eq("ba", ba, ad[15:14] == rom_base_bits);
    check_eq("rom_addr", rom_addr, ad[13:0]);
    if (check_rd) check_eq("rd_data", rd_data, expect_read(ad));
  endtask

  // Drives one bus cycle on the rising edge and checks it at the falling edge
  task automatic bus_cycle(input logic [15:0] a, input logic we, input logic [7:0] d,
                           input logic check_rd);
    logic [31:0] rnd;
    logic [31:0] pins;
    rnd  = $random(seed);
    pins = $random(seed);
    @(posedge clk);
    ad       <= a;
    wr       <= we;
    dout     <= d;
    cen      <= rnd[0];
    din      <= rnd[15:8];
    rom_data <= rnd[23:16];
    p1_din   <= pins[7:0];
    p2_din   <= pins[12:8];
    p6_din   <= pins[23:16];
    @(negedge clk);
    check_cycle(check_rd);
  endtask

  // ********************
  // Test sequences
  // ********************
  task automatic reset_checks();
    bus_cycle(treg(tmr_tcsr), 1'b0, 8'h00, 1'b1);
    check_eq("tcsr", rd_data, 8'h20);
    check_eq("p1_dout", p1_dout, port_mask[0]);
    check_eq("p2_dout", p2_dout, port_mask[1][4:0]);
    check_eq("p6_dout", p6_dout, port_mask[2]);
    check_eq("irq2", irq2, 1'b0);
    bus_cycle(treg(tmr_ocrh), 1'b0, 8'h00, 1'b1);
    check_eq("ocrh", rd_data, ocr_reset[15:8]);
    bus_cycle(treg(tmr_ocrl), 1'b0, 8'h00, 1'b1);
    check_eq("ocrl", rd_data, ocr_reset[7:0]);
    bus_cycle(treg(tmr_icrh), 1'b0, 8'h00, 1'b1);
    check_eq("icrh", rd_data, icr_reset[15:8]);
    bus_cycle(treg(tmr_icrl), 1'b0, 8'h00, 1'b1);
    check_eq("icrl", rd_data, icr_reset[7:0]);
    bus_cycle(treg(tmr_rmc), 1'b0, 8'h00, 1'b1);
    check_eq("rmc", rd_data, rmc_reset);
  endtask

  task automatic ram_ops();
    logic [31:0] rnd;
    logic [15:0] a;
    repeat (n_ram_ops) begin
      rnd = $random(seed);
      if (ram_written.size() == 0 || rnd[0]) begin
        a = ram_start + {8'd0, rnd[15:8]};
        bus_cycle(a, 1'b1, rnd[23:16], 1'b0);
        ram_written.push_back(a);
      end else begin
        a = ram_written[rnd[31:16] % ram_written.size()];
        bus_cycle(a, 1'b0, 8'h00, 1'b0);  // Registered read needs a second cycle
        bus_cycle(a, 1'b0, 8'h00, 1'b1);
      end
    end
  endtask

  task automatic compare_flag_test();
    int n;
    bus_cycle(treg(tmr_tcsr), 1'b1, 8'h08, 1'b1);
    bus_cycle(treg(tmr_frch), 1'b1, 8'h10, 1'b1);
    bus_cycle(treg(tmr_frcl), 1'b1, 8'h00, 1'b1);
    bus_cycle(treg(tmr_ocrh), 1'b1, 8'h10, 1'b1);
    bus_cycle(treg(tmr_ocrl), 1'b1, 8'h18, 1'b1);
    n = 0;
    while (!m_ocf && n < flag_wait_max) begin
      bus_cycle(treg(tmr_tcsr), 1'b0, 8'h00, 1'b1);
      n++;
    end
    if (!m_ocf) begin
      $display("Output compare flag never set within %0d cycles", flag_wait_max);
      $display("Checks failed");
      $fatal(1);
    end
    check_eq("irq2", irq2, 1'b1);
    bus_cycle(treg(tmr_ocrl), 1'b1, 8'h18, 1'b1);  // Rewrite clears the flag
    bus_cycle(treg(tmr_tcsr), 1'b0, 8'h00, 1'b1);
    check_eq("irq2", irq2, 1'b0);
    check_eq("tcsr", rd_data, 8'h28);
  endtask

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired before the test sequence finished");
    $display("Checks failed");
    $fatal(1);
  end

  initial begin
    logic [31:0] rnd;
    logic [15:0] a;
    seed = 32'h8871d647;
    rst = 1'b1;
    cen = 1'b0;
    wr = 1'b0;
    ad = 16'h4000;
    dout = 8'h00;
    din = 8'h00;
    rom_data = 8'h00;
    p1_din = 8'h00;
    p2_din = 5'h00;
    p6_din = 8'h00;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    reset_checks();
    repeat (n_port_ops) begin
      rnd = $random(seed);
      bus_cycle(port_addr[rnd[7:0] % num_ports], rnd[8], rnd[23:16], 1'b1);
    end
    ram_ops();
    bus_cycle(treg(tmr_rg5), 1'b1, 8'h5a, 1'b1);  // Known scratch and buffer
    bus_cycle(treg(tmr_frch), 1'b1, 8'h00, 1'b1);
    repeat (n_timer_ops) begin
      rnd = $random(seed);
      bus_cycle(treg(tmr_regs[rnd[7:0] % 9]), rnd[8], rnd[23:16], 1'b1);
    end
    compare_flag_test();
    repeat (n_prio_ops) begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'd0, 2'd1: a = {rom_base_bits, rnd[29:16]};
        2'd2:       a = {rnd[2] ? 2'b10 : 2'b01, rnd[29:16]};
        default:    a = {10'd0, rnd[21:16]};  // Register page including unmapped holes
      endcase
      bus_cycle(a, 1'b0, 8'h00, 1'b1);
      if (rnd[1:0] != 2'd3) check_eq("rd_data", rd_data, rnd[1] ? din : rom_data);
    end
    bus_cycle(16'h4000, 1'b0, 8'h00, 1'b1);
    $display("All checks passed");
    $finish;
  end

endmodule

/* mcu_periph_top.f */
hw/mcu_periph_pkg.sv
hw/bus_decode.sv
hw/io_port.sv
hw/work_ram.sv
hw/frc_timer.sv
hw/read_mux.sv
hw/mcu_periph_top.sv
sim/tb_mcu_periph.sv
